//--- design/oflow_pkg.sv
// shared widths, sizes and the controller enum for the tracking core
// one set holds up to pe_num boxes, a frame at most max_bboxes
// identity 0 is reserved and means no box on that lane
`default_nettype none

package oflow_pkg;

	// --------------------
	// sizes
	// --------------------
	localparam int pe_num     = 4;  // processing elements, also boxes per set
	localparam int max_bboxes = 8;  // two sets per frame at most

	// --------------------
	// field types
	// --------------------
	typedef logic [7:0]  coord_t;     // one box field
	typedef logic [31:0] bbox_t;      // x,y,w,h from msb down
	typedef logic [7:0]  id_t;        // tracking identity, 0 = none
	typedef logic [3:0]  weight_t;    // reg file weight
	typedef logic [15:0] score_t;     // lower is more similar
	typedef logic [2:0]  addr_t;      // buffer entry index
	typedef logic [2:0]  lane_cnt_t;  // valid boxes in a set, 1..4

	// --------------------
	// matching
	// --------------------
	// worst case score is 15*510 + 15*510, fits 16 bits
	localparam score_t match_th  = 16'd64;  // highest score still a match
	localparam score_t score_max = '1;      // clear value of running min

	// controller states
	typedef enum logic [1:0] {
		s_idle,   // wait for a set
		s_read,   // scan the previous frame
		s_drain,  // last read reaches the elements
		s_out     // ids on the output channel
	} core_state_t;

endpackage

`default_nettype wire

//--- design/oflow_pe.sv
// one box-scoring element
// score = pos_w*(|dx|+|dy|) + size_w*(|dw|+|dh|), lower is closer
// strict compare keeps the lowest index on equal scores
`timescale 1ns/10ps
`default_nettype none

module oflow_pe import oflow_pkg::*; (
	input  logic    clk,
	input  logic    rst_n_i,
	input  bbox_t   bbox_i,          // current box of this lane
	input  logic    clear_i,         // new set accepted
	input  logic    prev_valid_i,
	input  bbox_t   prev_bbox_i,     // broadcast previous entry
	input  id_t     prev_id_i,
	input  weight_t pos_weight_i,
	input  weight_t size_weight_i,
	output logic    match_o,
	output id_t     match_id_o
);

	coord_t     dx;
	coord_t     dy;
	coord_t     dw;
	coord_t     dh;
	logic [8:0] pos_sum;     // |dx|+|dy|, up to 510
	logic [8:0] size_sum;
	score_t     score;
	score_t     best_score;  // running min

	function automatic coord_t abs_diff(input coord_t a, input coord_t b);
		return (a > b) ? (a - b) : (b - a);
	endfunction

	// --------------------
	// field differences
	// --------------------
	assign dx = abs_diff(bbox_i[31:24], prev_bbox_i[31:24]);
	assign dy = abs_diff(bbox_i[23:16], prev_bbox_i[23:16]);
	assign dw = abs_diff(bbox_i[15:8],  prev_bbox_i[15:8]);
	assign dh = abs_diff(bbox_i[7:0],   prev_bbox_i[7:0]);

	assign pos_sum  = {1'b0, dx} + {1'b0, dy};
	assign size_sum = {1'b0, dw} + {1'b0, dh};

	// weighted score, no overflow at 16 bits
	assign score = score_t'(pos_weight_i)  * score_t'(pos_sum)
	             + score_t'(size_weight_i) * score_t'(size_sum);

	// --------------------
	// running minimum
	// --------------------
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			best_score <= score_max;
			match_id_o <= '0;
		end else if (clear_i) begin
			best_score <= score_max;   // start of every set
			match_id_o <= '0;
		end else if (prev_valid_i && (score < best_score)) begin
			best_score <= score;       // ties keep the earlier entry
			match_id_o <= prev_id_i;
		end
	end

	// score_max is above the threshold, so low after a clear
	assign match_o = (best_score <= match_th);

endmodule

`default_nettype wire

//--- design/oflow_mem_buffer.sv
// two-bank frame store, one box and one id per entry
// reads come from the previous bank with one cycle latency
// writes go to the current bank, swap flips the banks on the same edge
`timescale 1ns/10ps
`default_nettype none

module oflow_mem_buffer import oflow_pkg::*; (
	input  logic      clk,
	input  logic      rst_n_i,
	input  logic      rd_en_i,
	input  addr_t     rd_addr_i,
	input  logic      wr_en_i,
	input  addr_t     wr_base_i,       // first entry of this set
	input  lane_cnt_t wr_count_i,      // lanes below this are written
	input  bbox_t     wr_bboxes_i [pe_num],
	input  id_t       wr_ids_i [pe_num],
	input  logic      swap_i,
	output bbox_t     rd_bbox_o,
	output id_t       rd_id_o,
	output logic      rd_valid_o
);

	bbox_t box_mem [2][max_bboxes];
	id_t   id_mem  [2][max_bboxes];
	logic  bank_sel;                  // bank holding the previous frame

	// bank select and read strobe
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			bank_sel   <= 1'b0;
			rd_valid_o <= 1'b0;
		end else begin
			rd_valid_o <= rd_en_i;      // data follows request by one cycle
			if (swap_i)
				bank_sel <= ~bank_sel;  // current frame becomes previous
		end
	end

	// --------------------
	// storage
	// --------------------
	always_ff @(posedge clk) begin
		if (rd_en_i) begin
			rd_bbox_o <= box_mem[bank_sel][rd_addr_i];
			rd_id_o   <= id_mem[bank_sel][rd_addr_i];
		end
		if (wr_en_i) begin
			for (int l = 0; l < pe_num; l++) begin
				if (lane_cnt_t'(l) < wr_count_i) begin
					// old bank_sel here, so the last set lands in the new previous bank
					box_mem[~bank_sel][wr_base_i + addr_t'(l)] <= wr_bboxes_i[l];
					id_mem[~bank_sel][wr_base_i + addr_t'(l)]  <= wr_ids_i[l];
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- design/oflow_id_assign.sv
// identity assigner, combinational per lane
// fresh ids are handed out in lane order from a running counter
// counter starts at 1 and never wraps in normal use, kept below 255
`timescale 1ns/10ps
`default_nettype none

module oflow_id_assign import oflow_pkg::*; (
	input  logic      clk,
	input  logic      rst_n_i,
	input  lane_cnt_t set_count_i,
	input  logic      match_i [pe_num],
	input  id_t       match_ids_i [pe_num],
	input  logic      commit_i,          // output transfer
	output id_t       ids_o [pe_num]
);

	id_t       id_cnt;     // next fresh identity
	lane_cnt_t fresh_cnt;  // unmatched valid lanes in the set

	// --------------------
	// per lane choice
	// --------------------
	always_comb begin
		fresh_cnt = '0;
		for (int l = 0; l < pe_num; l++) begin
			ids_o[l] = '0;                         // unused lane
			if (lane_cnt_t'(l) < set_count_i) begin
				if (match_i[l]) begin
					ids_o[l] = match_ids_i[l];         // inherit
				end else begin
					ids_o[l]  = id_cnt + id_t'(fresh_cnt);  // fresh below this lane
					fresh_cnt = fresh_cnt + 1'b1;
				end
			end
		end
	end

	// counter moves only on commit, survives frame boundaries
	always_ff @(posedge clk) begin
		if (!rst_n_i)
			id_cnt <= id_t'(1);
		else if (commit_i)
			id_cnt <= id_cnt + id_t'(fresh_cnt);
	end

endmodule

`default_nettype wire

//--- design/oflow_core_fsm.sv
// set controller of the tracking core
// frame ends with the set flagged last, the next set starts a new frame
// read length is the box count of the previous frame, 0 after reset
// the testbench keeps a frame at or below max_bboxes boxes
`timescale 1ns/10ps
`default_nettype none

module oflow_core_fsm import oflow_pkg::*; (
	input  logic        clk,
	input  logic        rst_n_i,
	input  logic        set_valid_i,
	input  bbox_t       bboxes_i [pe_num],
	input  lane_cnt_t   set_count_i,
	input  logic        last_set_i,
	input  logic        id_ready_i,
	output logic        set_ready_o,
	output logic        id_valid_o,
	output logic        done_frame_o,
	output bbox_t       cur_bboxes_o [pe_num],
	output lane_cnt_t   cur_count_o,
	output logic        clear_o,
	output logic        rd_en_o,
	output addr_t       rd_addr_o,
	output logic        commit_o,
	output addr_t       wr_base_o,
	output logic        swap_o,
	output logic [3:0]  prev_count_o   // up to 8 stored entries
);

	core_state_t state;
	logic        cur_last;             // set closes the frame
	logic [3:0]  frame_cnt;            // boxes committed so far this frame
	logic [$clog2(max_bboxes/pe_num)-1:0] set_idx;  // set number inside frame

	// --------------------
	// handshakes
	// --------------------
	assign set_ready_o = (state == s_idle);
	assign id_valid_o  = (state == s_out);
	assign clear_o     = set_valid_i & set_ready_o;  // accept edge
	assign commit_o    = id_valid_o & id_ready_i;    // output transfer edge
	assign swap_o      = commit_o & cur_last;
	assign rd_en_o     = (state == s_read);          // one read per cycle
	assign wr_base_o   = addr_t'(set_idx * pe_num);

	// control state
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state        <= s_idle;
			cur_count_o  <= '0;
			cur_last     <= 1'b0;
			rd_addr_o    <= '0;
			set_idx      <= '0;
			frame_cnt    <= '0;
			prev_count_o <= '0;
			done_frame_o <= 1'b0;
		end else begin
			done_frame_o <= swap_o;   // one cycle after the last transfer
			case (state)
				s_idle: begin
					if (set_valid_i) begin
						cur_count_o <= set_count_i;
						cur_last    <= last_set_i;
						rd_addr_o   <= '0;
						// nothing stored yet, go straight to drain
						state <= (prev_count_o == 4'd0) ? s_drain : s_read;
					end
				end
				s_read: begin
					if ({1'b0, rd_addr_o} == prev_count_o - 4'd1)
						state <= s_drain;           // last entry issued
					else
						rd_addr_o <= rd_addr_o + 1'b1;
				end
				s_drain: begin
					state <= s_out;                 // last data lands in the pe's
				end
				s_out: begin
					if (id_ready_i) begin
						state <= s_idle;
						if (cur_last) begin
							// stored entries of the frame just closed
							prev_count_o <= frame_cnt + {1'b0, cur_count_o};
							frame_cnt    <= '0;
							set_idx      <= '0;
						end else begin
							frame_cnt <= frame_cnt + {1'b0, cur_count_o};
							set_idx   <= set_idx + 1'b1;
						end
					end
				end
				default: state <= s_idle;
			endcase
		end
	end

	// set payload, loaded on accept only
	always_ff @(posedge clk) begin
		if (clear_o)
			cur_bboxes_o <= bboxes_i;
	end

endmodule

`default_nettype wire

//--- design/oflow_core.sv
// top of the reduced box tracking core
// one set in flight at a time, each set sees the whole previous frame
// no conflict resolution, two boxes may inherit the same identity
// weights must stay stable while a set is in flight
`timescale 1ns/10ps
`default_nettype none

module oflow_core import oflow_pkg::*; (
	input  logic      clk,
	input  logic      rst_n_i,
	// set input channel
	input  logic      set_valid_i,
	input  bbox_t     bboxes_i [pe_num],
	input  lane_cnt_t set_count_i,
	input  logic      last_set_i,
	output logic      set_ready_o,
	// reg file
	input  weight_t   pos_weight_i,
	input  weight_t   size_weight_i,
	// identity output channel
	input  logic      id_ready_i,
	output logic      id_valid_o,
	output id_t       ids_o [pe_num],
	output logic      done_frame_o
);

	// --------------------
	// wires
	// --------------------
	bbox_t     cur_bboxes [pe_num];  // registered set
	lane_cnt_t cur_count;
	logic      clear;                // accept pulse to the elements
	logic      rd_en;
	addr_t     rd_addr;
	logic      commit;               // output transfer
	addr_t     wr_base;
	logic      swap;
	bbox_t     rd_bbox;              // broadcast previous entry
	id_t       rd_id;
	logic      rd_valid;
	logic      match [pe_num];
	id_t       match_ids [pe_num];

	// controller
	oflow_core_fsm oflow_core_fsm_i (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.set_valid_i  (set_valid_i),
		.bboxes_i     (bboxes_i),
		.set_count_i  (set_count_i),
		.last_set_i   (last_set_i),
		.id_ready_i   (id_ready_i),
		.set_ready_o  (set_ready_o),
		.id_valid_o   (id_valid_o),
		.done_frame_o (done_frame_o),
		.cur_bboxes_o (cur_bboxes),
		.cur_count_o  (cur_count),
		.clear_o      (clear),
		.rd_en_o      (rd_en),
		.rd_addr_o    (rd_addr),
		.commit_o     (commit),
		.wr_base_o    (wr_base),
		.swap_o       (swap),
		.prev_count_o ()              // read length, used inside the fsm only
	);

	// previous/current frame store
	oflow_mem_buffer oflow_mem_buffer_i (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.rd_en_i     (rd_en),
		.rd_addr_i   (rd_addr),
		.wr_en_i     (commit),
		.wr_base_i   (wr_base),
		.wr_count_i  (cur_count),
		.wr_bboxes_i (cur_bboxes),
		.wr_ids_i    (ids_o),        // final ids go back as next frame's history
		.swap_i      (swap),
		.rd_bbox_o   (rd_bbox),
		.rd_id_o     (rd_id),
		.rd_valid_o  (rd_valid)
	);

	// --------------------
	// processing elements
	// --------------------
	genvar i;
	generate
		for (i = 0; i < pe_num; i++) begin : pe_inst
			oflow_pe oflow_pe_i (
				.clk           (clk),
				.rst_n_i       (rst_n_i),
				.bbox_i        (cur_bboxes[i]),
				.clear_i       (clear),
				.prev_valid_i  (rd_valid),
				.prev_bbox_i   (rd_bbox),
				.prev_id_i     (rd_id),
				.pos_weight_i  (pos_weight_i),
				.size_weight_i (size_weight_i),
				.match_o       (match[i]),
				.match_id_o    (match_ids[i])
			);
		end
	endgenerate

	// inherited or fresh identity per lane
	oflow_id_assign oflow_id_assign_i (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.set_count_i (cur_count),
		.match_i     (match),
		.match_ids_i (match_ids),
		.commit_i    (commit),
		.ids_o       (ids_o)
	);

endmodule

`default_nettype wire

//--- testbench/oflow_core_sva.sv
// handshake assertions for the tracking core, bound to the top level
// checks start after reset is released
`timescale 1ns/10ps
`default_nettype none

module oflow_core_sva import oflow_pkg::*; (
	input logic clk,
	input logic rst_n_i,
	input logic set_ready_o,
	input logic id_valid_o,
	input logic id_ready_i,
	input id_t  ids_o [pe_num],
	input logic done_frame_o
);

	logic [8*pe_num-1:0] ids_flat;   // lanes packed for $stable

	always_comb begin
		for (int l = 0; l < pe_num; l++)
			ids_flat[8*l +: 8] = ids_o[l];
	end

	// output channel holds under back-pressure
	hold_a: assert property (@(posedge clk) disable iff (!rst_n_i)
		id_valid_o && !id_ready_i |=> id_valid_o && $stable(ids_flat))
		else $error("ids_o or id_valid_o moved while id_ready_i was low");

	// one set in flight
	excl_a: assert property (@(posedge clk) disable iff (!rst_n_i)
		!(set_ready_o && id_valid_o))
		else $error("set_ready_o high while id_valid_o high");

	done_a: assert property (@(posedge clk) disable iff (!rst_n_i)
		done_frame_o |=> !done_frame_o)
		else $error("done_frame_o high two cycles in a row");

endmodule

`default_nettype wire

//--- testbench/oflow_core_tb.sv
// self-checking testbench for the tracking core, reference model in tb
// non-last sets are always full, the core stores a frame by set base
// the fresh id counter stays far below 255 over all tests
`timescale 1ns/10ps
`default_nettype none

module oflow_core_tb import oflow_pkg::*; ();

	localparam int total_sets  = 32;    // upper bound, all tests
	localparam int stall_allow = 400;   // cycles lost to ready stalls
	localparam int cycle_limit = total_sets * (max_bboxes + 10) + stall_allow + 10;
	localparam int rnd_frames  = 10;

	logic clk, rst_n, set_valid, last_set, set_ready, id_ready, id_valid, done_frame;
	bbox_t     bboxes [pe_num];
	lane_cnt_t set_count;
	weight_t   pos_w, size_w;
	id_t       ids [pe_num];

	// --------------------
	// model state
	// --------------------
	bbox_t prev_box [max_bboxes];  // stored previous frame
	id_t   prev_id [max_bboxes];
	bbox_t cur_box [max_bboxes];   // frame being built
	id_t   cur_id [max_bboxes];
	int    prev_n, cur_n;
	int    model_cnt;              // next fresh id
	bbox_t set_boxes [pe_num];
	bbox_t frame_boxes [max_bboxes];
	bbox_t rnd_box [rnd_frames][max_bboxes];
	int    rnd_n [rnd_frames];
	logic [31:0] exp_q [$];        // lane 0 in low byte
	logic        last_q [$];
	logic [31:0] exp_ids, rnd, rng_state;
	logic  stall_en, done_exp, held;
	id_t   held_ids [pe_num];
	int    err_cnt, err_mark, test_num, sets_checked, cycles;

	oflow_core oflow_core_i (
		.clk           (clk),
		.rst_n_i       (rst_n),
		.set_valid_i   (set_valid),
		.bboxes_i      (bboxes),
		.set_count_i   (set_count),
		.last_set_i    (last_set),
		.set_ready_o   (set_ready),
		.pos_weight_i  (pos_w),
		.size_weight_i (size_w),
		.id_ready_i    (id_ready),
		.id_valid_o    (id_valid),
		.ids_o         (ids),
		.done_frame_o  (done_frame)
	);

	bind oflow_core oflow_core_sva oflow_core_sva_i (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.set_ready_o  (set_ready_o),
		.id_valid_o   (id_valid_o),
		.id_ready_i   (id_ready_i),
		.ids_o        (ids_o),
		.done_frame_o (done_frame_o)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic bbox_t make_box(input int x, input int y, input int w, input int h);
		return {coord_t'(x), coord_t'(y), coord_t'(w), coord_t'(h)};
	endfunction

	// weighted sum of absolute field differences
	function automatic int box_score(input bbox_t a, input bbox_t b);
		int d [4];
		for (int f = 0; f < 4; f++) begin
			d[f] = int'(a[8*f +: 8]) - int'(b[8*f +: 8]);
			if (d[f] < 0)
				d[f] = -d[f];
		end
		return int'(pos_w) * (d[3] + d[2]) + int'(size_w) * (d[1] + d[0]);  // x,y then w,h
	endfunction

	// expected ids of one set, also updates the frame model and counter
	function automatic logic [31:0] ref_ids(input int cnt, input logic last);
		logic [31:0] res;
		int best, bid, sc, fresh;
		res   = '0;
		fresh = 0;
		for (int l = 0; l < cnt; l++) begin
			best = int'(score_max);
			bid  = 0;
			for (int p = 0; p < prev_n; p++) begin
				sc = box_score(set_boxes[l], prev_box[p]);
				if (sc < best) begin   // strict, lowest index wins a tie
					best = sc;
					bid  = prev_id[p];
				end
			end
			if (best <= int'(match_th))
				res[8*l +: 8] = id_t'(bid);
			else begin
				res[8*l +: 8] = id_t'(model_cnt + fresh);
				fresh++;
			end
			cur_box[cur_n] = set_boxes[l];
			cur_id[cur_n]  = res[8*l +: 8];
			cur_n++;
		end
		model_cnt += fresh;
		if (last) begin    // frame closes, becomes history
			prev_box = cur_box;
			prev_id  = cur_id;
			prev_n   = cur_n;
			cur_n    = 0;
		end
		return res;
	endfunction

	task automatic send_set(input int cnt, input logic last);
		exp_q.push_back(ref_ids(cnt, last));
		last_q.push_back(last);
		@(posedge clk);
		#2;
		set_valid = 1'b1;
		bboxes    = set_boxes;
		set_count = lane_cnt_t'(cnt);
		last_set  = last;
		do
			@(negedge clk);
		while (!set_ready);
		@(posedge clk);    // transfer edge
		#2;
		set_valid = 1'b0;
	endtask

	// full sets first, partial set last
	task automatic send_frame(input int n);
		int cnt;
		for (int s = 0; s * pe_num < n; s++) begin
			cnt = (n - s * pe_num > pe_num) ? pe_num : n - s * pe_num;
			for (int l = 0; l < pe_num; l++)
				set_boxes[l] = (l < cnt) ? frame_boxes[s * pe_num + l]
				                         : bbox_t'(32'h0101_0101 * (l + 1));  // junk lane
			send_set(cnt, (s + 1) * pe_num >= n);
		end
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0)
			@(posedge clk);
		repeat (2) @(posedge clk);   // past the done pulse
		#2;
	endtask

	task automatic end_test(input string name);
		test_num++;
		$display("test %0d %s: %s, %0d errors", test_num, name,
			(err_cnt == err_mark) ? "ok" : "mismatch", err_cnt - err_mark);
		err_mark = err_cnt;
	endtask

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// random ready stalls, only while enabled
	initial begin
		forever begin
			@(posedge clk);
			#2;
			id_ready = stall_en ? ((next_rand() % 4) != 0) : 1'b1;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("timeout after %0d cycles, a set never came out", cycles);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// --------------------
	// compare, sampled mid cycle
	// --------------------
	always @(negedge clk) begin
		if (!rst_n) begin
			done_exp = 1'b0;
			held     = 1'b0;
		end else begin
			if (done_frame !== done_exp) begin
				$display("** Error: done_frame_o = %h, expected %h", done_frame, done_exp);
				err_cnt++;
			end
			if (set_ready && id_valid) begin
				$display("set_ready_o and id_valid_o are high in the same cycle");
				err_cnt++;
			end
			if (held && !id_valid) begin
				$display("id_valid_o dropped while id_ready_i was low");
				err_cnt++;
			end else if (held) begin
				for (int l = 0; l < pe_num; l++)
					if (ids[l] !== held_ids[l]) begin
						$display("** Error: ids_o[%0d] = %h under back-pressure, held %h",
							l, ids[l], held_ids[l]);
						err_cnt++;
					end
			end
			held     = id_valid && !id_ready;
			held_ids = ids;
			done_exp = 1'b0;
			if (id_valid && id_ready && exp_q.size() == 0) begin
				$display("output transfer with no set pending, a set came out twice");
				err_cnt++;
			end else if (id_valid && id_ready) begin
				exp_ids  = exp_q.pop_front();
				done_exp = last_q.pop_front();   // pulse due next cycle
				sets_checked++;
				for (int l = 0; l < pe_num; l++)
					if (ids[l] !== exp_ids[8*l +: 8]) begin
						$display("** Error: ids_o[%0d] = %h, expected %h", l, ids[l],
							exp_ids[8*l +: 8]);
						err_cnt++;
					end
			end
		end
	end

	initial begin
		rst_n     = 1'b0;
		set_valid = 1'b0;
		set_count = '0;
		last_set  = 1'b0;
		id_ready  = 1'b1;
		pos_w     = 4'd2;
		size_w    = 4'd1;
		for (int l = 0; l < pe_num; l++)
			bboxes[l] = '0;
		rng_state = 32'h229c;
		stall_en  = 1'b0;
		done_exp  = 1'b0;
		held      = 1'b0;
		prev_n    = 0;
		cur_n     = 0;
		model_cnt = 1;    // counter after reset
		{err_cnt, err_mark, test_num, sets_checked, cycles} = '0;
		repeat (5) @(posedge clk);
		#2;
		rst_n = 1'b1;

		// first frame, six fresh ids
		for (int k = 0; k < 6; k++)
			frame_boxes[k] = make_box(20 + 30 * k, 40 + 20 * k, 16, 12 + k);
		send_frame(6);
		wait_drain();
		end_test("first frame");

		for (int k = 0; k < 6; k++)
			frame_boxes[k] = make_box(23 + 30 * k, 42 + 20 * k, 16, 12 + k);  // small move
		send_frame(6);
		wait_drain();
		end_test("small moves");

		// near and far boxes interleaved, partial last set
		for (int k = 0; k < 4; k++)
			frame_boxes[(k == 0) ? 0 : (k == 3) ? 5 : k + 1] =
				make_box(25 + 30 * k, 43 + 20 * k, 17, 12 + k);
		for (int j = 0; j < 3; j++)
			frame_boxes[(j == 0) ? 1 : 2 * j + 2] = make_box(10 + 60 * j, 230, 30, 30);
		send_frame(7);
		wait_drain();
		end_test("mixed frame");

		// --------------------
		// size weight off, then large
		// --------------------
		size_w = 4'd0;
		for (int k = 0; k < 3; k++)
			frame_boxes[k] = make_box(25 + 30 * k, 43 + 20 * k, 37, 32 + k);
		send_frame(3);
		for (int k = 0; k < 3; k++)
			frame_boxes[k] = make_box(25 + 30 * k, 43 + 20 * k, 17, 12 + k);
		send_frame(3);
		wait_drain();
		size_w = 4'd15;
		for (int k = 0; k < 3; k++)
			frame_boxes[k] = make_box(25 + 30 * k, 43 + 20 * k, 37, 32 + k);
		send_frame(3);
		wait_drain();
		end_test("weights");

		// random frames, half the boxes nudged from the frame before
		pos_w  = 4'd1;
		size_w = 4'd1;
		@(negedge clk);
		for (int f = 0; f < rnd_frames; f++) begin
			rnd_n[f] = 1 + int'(next_rand() % 8);
			for (int b = 0; b < rnd_n[f]; b++) begin
				rnd = next_rand();
				if (f > 0 && rnd[0]) begin
					rnd_box[f][b] = rnd_box[f-1][int'(rnd[10:8]) % rnd_n[f-1]];
					rnd_box[f][b] = make_box(int'(rnd_box[f][b][31:24]) + int'(rnd[17:16]),
						int'(rnd_box[f][b][23:16]) + int'(rnd[19:18]),
						int'(rnd_box[f][b][15:8]), int'(rnd_box[f][b][7:0]) + int'(rnd[20]));
				end else
					rnd_box[f][b] = next_rand();
			end
		end
		stall_en = 1'b1;
		for (int f = 0; f < rnd_frames; f++) begin
			for (int b = 0; b < rnd_n[f]; b++)
				frame_boxes[b] = rnd_box[f][b];
			send_frame(rnd_n[f]);
		end
		wait_drain();
		@(negedge clk);
		stall_en = 1'b0;
		end_test("back-pressure");

		// two stored boxes at equal distance
		@(posedge clk);
		#2;
		pos_w  = 4'd2;
		frame_boxes[0] = make_box(100, 100, 20, 20);
		frame_boxes[1] = make_box(108, 100, 20, 20);
		send_frame(2);
		frame_boxes[0] = make_box(104, 100, 20, 20);
		frame_boxes[1] = make_box(104, 101, 20, 20);
		send_frame(2);
		wait_drain();
		end_test("ties");

		$display("%0d tests, %0d sets checked, %0d errors", test_num, sets_checked, err_cnt);
		if (err_cnt == 0 && exp_q.size() == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
design/oflow_pkg.sv
design/oflow_pe.sv
design/oflow_mem_buffer.sv
design/oflow_id_assign.sv
design/oflow_core_fsm.sv
design/oflow_core.sv
testbench/oflow_core_sva.sv
testbench/oflow_core_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = oflow_core_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
